// ==== wb_pkg.sv ====
// Writeback widths and packet format for the two-group back end
// Group 0 carries the ALU alone and group 1 the multiplier and divider
// Group and unit counts are fixed and the RTL relies on them
package wb_pkg;

    //////////////////////////////
    // Data and id widths
    //////////////////////////////
    localparam int XLEN = 32;
    localparam int ID_W = 4;

    // Instruction id as tagged at issue
    typedef logic [ID_W-1:0] id_t;

    // One integer data word
    typedef logic [XLEN-1:0] xlen_t;

    //////////////////////////////
    // Writeback groups
    //////////////////////////////
    localparam int NUM_WB_GROUPS = 2;

    // Multiplier and divider share group 1
    localparam int NUM_G1_UNITS = 2;

    // One result per group per cycle
    typedef struct packed {
        logic  valid;
        id_t   id;
        xlen_t data;
    } wb_packet_t;

endpackage

// ==== unit_pkg.sv ====
// Unit select codes and per-unit operation codes
// The op field is decoded differently by each unit
package unit_pkg;

    // Unit select as driven on issue
    typedef enum logic [1:0] {
        UNIT_ALU = 2'd0,
        UNIT_MUL = 2'd1,
        UNIT_DIV = 2'd2
    } unit_code_t;

    localparam int NUM_UNITS = 3;

    typedef logic [2:0] op_t;

    //////////////////////////////
    // ALU ops, SLT is signed
    localparam op_t ALU_ADD = 3'd0;
    localparam op_t ALU_SUB = 3'd1;
    localparam op_t ALU_AND = 3'd2;
    localparam op_t ALU_OR  = 3'd3;
    localparam op_t ALU_XOR = 3'd4;
    localparam op_t ALU_SLL = 3'd5;
    localparam op_t ALU_SRL = 3'd6;
    localparam op_t ALU_SLT = 3'd7;

    // Multiplier ops on the unsigned product
    localparam op_t MUL_LO = 3'd0;
    localparam op_t MUL_HU = 3'd1;

    // Divider ops, both unsigned
    localparam op_t DIVU = 3'd0;
    localparam op_t REMU = 3'd1;

    // Register stages from issue to done
    localparam int MUL_STAGES = 3;

endpackage

// ==== unit_wb_if.sv ====
// Completion of one unit toward writeback
// done, id and rd are held by the unit until ack
`timescale 1ns/100ps

interface unit_wb_if
    import wb_pkg::*;
();

    logic  done;
    id_t   id;
    xlen_t rd;
    // Driven combinationally by writeback
    logic  ack;

    // Producing unit
    modport unit (output done, output id, output rd, input ack);

    // Writeback arbiter
    modport wb (input done, input id, input rd, output ack);

endinterface

// ==== unit_issue_if.sv ====
// One issued instruction toward a single unit
// Transfer happens on a clock edge with valid and ready both high
`timescale 1ns/100ps

interface unit_issue_if
    import wb_pkg::*;
    import unit_pkg::*;
();

    logic  valid;
    op_t   op;
    xlen_t a;
    xlen_t b;
    id_t   id;
    logic  ready;

    // Issue side at the top level
    modport src (output valid, output op, output a, output b, output id, input ready);

    // Execution unit
    modport unit (input valid, input op, input a, input b, input id, output ready);

endinterface

// ==== priority_encoder.sv ====
// Lowest index wins
// Width is the group 1 unit count so sel is a single bit
`timescale 1ns/100ps

module priority_encoder
    import wb_pkg::*;
(
    input  logic [NUM_G1_UNITS-1:0] vec,
    output logic                    sel,
    output logic                    any
);

    assign any = |vec;

    // Scan from the top so the lowest set bit is written last
    always_comb begin
        sel = 1'b0;
        for (int i = NUM_G1_UNITS - 1; i >= 0; i--) begin
            if (vec[i]) begin
                sel = i[0];
            end
        end
    end

endmodule

// ==== alu_unit.sv ====
// Single-cycle integer ALU with a registered result
// Always ready, result is held until writeback acks it
// Shifts use the low five bits of b
`timescale 1ns/100ps

module alu_unit
    import wb_pkg::*;
    import unit_pkg::*;
(
    input logic        clk,
    input logic        rst,
    unit_issue_if.unit issue,
    unit_wb_if.unit    wb
);

    logic  accept;
    xlen_t result;

    assign issue.ready = 1'b1;
    assign accept      = issue.valid && issue.ready;

    //////////////////////////////
    // Operation decode
    //////////////////////////////
    always_comb begin
        case (issue.op)
            ALU_ADD: result = issue.a + issue.b;
            ALU_SUB: result = issue.a - issue.b;
            ALU_AND: result = issue.a & issue.b;
            ALU_OR:  result = issue.a | issue.b;
            ALU_XOR: result = issue.a ^ issue.b;
            ALU_SLL: result = issue.a << issue.b[$clog2(XLEN)-1:0];
            ALU_SRL: result = issue.a >> issue.b[$clog2(XLEN)-1:0];
            // Signed compare, result is 0 or 1
            ALU_SLT: result = {{(XLEN-1){1'b0}}, $signed(issue.a) < $signed(issue.b)};
            default: result = '0;
        endcase
    end

    // New issue wins over ack in the same cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            wb.done <= 1'b0;
        end else if (accept) begin
            wb.done <= 1'b1;
        end else if (wb.ack) begin
            wb.done <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            wb.id <= issue.id;
            wb.rd <= result;
        end
    end

endmodule

// ==== mul_unit.sv ====
// Three-stage unsigned multiplier pipeline
// Whole pipe holds while the last stage waits for ack
// Bubbles are not squeezed out during a stall
`timescale 1ns/100ps

module mul_unit
    import wb_pkg::*;
    import unit_pkg::*;
(
    input logic        clk,
    input logic        rst,
    unit_issue_if.unit issue,
    unit_wb_if.unit    wb
);

    logic                      adv;
    logic [MUL_STAGES-1:0]     stage_valid;
    id_t                       stage_id [MUL_STAGES];
    // Op is consumed by the last stage so it stops one short
    op_t                       stage_op [MUL_STAGES-1];
    logic [XLEN+XLEN/2-1:0]    pp_lo;
    logic [XLEN+XLEN/2-1:0]    pp_hi;
    logic [2*XLEN-1:0]         product;
    xlen_t                     result;

    // Stall when the output stage is full and not taken
    assign adv         = !(stage_valid[MUL_STAGES-1] && !wb.ack);
    assign issue.ready = adv;

    //////////////////////////////
    // Stage valids
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            stage_valid <= '0;
        end else if (adv) begin
            stage_valid <= {stage_valid[MUL_STAGES-2:0], issue.valid};
        end
    end

    //////////////////////////////
    // Datapath
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (adv) begin
            stage_id[0] <= issue.id;
            stage_op[0] <= issue.op;
            for (int s = 1; s < MUL_STAGES; s++) begin
                stage_id[s] <= stage_id[s-1];
            end
            for (int s = 1; s < MUL_STAGES - 1; s++) begin
                stage_op[s] <= stage_op[s-1];
            end
            // Stage 1 splits b into two half-width partial products
            pp_lo   <= issue.a * issue.b[XLEN/2-1:0];
            pp_hi   <= issue.a * issue.b[XLEN-1:XLEN/2];
            // Stage 2 aligns and sums them
            product <= {{(XLEN/2){1'b0}}, pp_lo} + {pp_hi, {(XLEN/2){1'b0}}};
            // Stage 3 picks the half
            result  <= (stage_op[MUL_STAGES-2] == MUL_HU) ? product[2*XLEN-1:XLEN]
                                                          : product[XLEN-1:0];
        end
    end

    assign wb.done = stage_valid[MUL_STAGES-1];
    assign wb.id   = stage_id[MUL_STAGES-1];
    assign wb.rd   = result;

endmodule

// ==== div_unit.sv ====
// Radix-2 restoring unsigned divider, one instruction in flight
// Done 33 cycles after issue and not ready again until acked
// Divide by zero yields all ones and the dividend as remainder
`timescale 1ns/100ps

module div_unit
    import wb_pkg::*;
    import unit_pkg::*;
(
    input logic        clk,
    input logic        rst,
    unit_issue_if.unit issue,
    unit_wb_if.unit    wb
);

    logic                      accept;
    logic                      busy;
    logic                      last;
    logic [$clog2(XLEN)-1:0]   count;
    op_t                       op_q;
    // Dividend shifts out as quotient bits shift in
    xlen_t                     quot;
    xlen_t                     rem;
    xlen_t                     divisor;
    logic [XLEN:0]             rem_shift;
    logic [XLEN+1:0]           diff;
    xlen_t                     quot_next;
    xlen_t                     rem_next;

    assign issue.ready = !busy && !wb.done;
    assign accept      = issue.valid && issue.ready;
    assign last        = busy && (count == '1);

    //////////////////////////////
    // One restoring step
    //////////////////////////////
    assign rem_shift = {rem, quot[XLEN-1]};
    assign diff      = {1'b0, rem_shift} - {2'b00, divisor};

    // Borrow out means the divisor did not fit
    always_comb begin
        if (diff[XLEN+1]) begin
            rem_next  = rem_shift[XLEN-1:0];
            quot_next = {quot[XLEN-2:0], 1'b0};
        end else begin
            rem_next  = diff[XLEN-1:0];
            quot_next = {quot[XLEN-2:0], 1'b1};
        end
    end

    //////////////////////////////
    // Control
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            busy    <= 1'b0;
            count   <= '0;
            wb.done <= 1'b0;
        end else if (accept) begin
            busy  <= 1'b1;
            count <= '0;
        end else if (busy) begin
            count <= count + 1'b1;
            // Last iteration raises done directly
            if (last) begin
                busy    <= 1'b0;
                wb.done <= 1'b1;
            end
        end else if (wb.ack) begin
            wb.done <= 1'b0;
        end
    end

    //////////////////////////////
    // Datapath
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (accept) begin
            quot    <= issue.a;
            rem     <= '0;
            divisor <= issue.b;
            op_q    <= issue.op;
            wb.id   <= issue.id;
        end else if (busy) begin
            quot <= quot_next;
            rem  <= rem_next;
            if (last) begin
                wb.rd <= (op_q == REMU) ? rem_next : quot_next;
            end
        end
    end

endmodule

// ==== writeback.sv ====
// Writeback arbitration for two fixed groups
// Group 0 is the ALU alone and is acked as soon as it is done
// Group 1 uses fixed priority with the lowest index first
// Packets and acks are combinational from done
`timescale 1ns/100ps

module writeback
    import wb_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    unit_wb_if.wb      alu_wb,
    unit_wb_if.wb      g1_wb [NUM_G1_UNITS],
    output wb_packet_t wb_packet [NUM_WB_GROUPS],
    output wb_packet_t wb_snoop
);

    logic [NUM_G1_UNITS-1:0] g1_done;
    logic [NUM_G1_UNITS-1:0] g1_ack;
    id_t                     g1_id [NUM_G1_UNITS];
    xlen_t                   g1_rd [NUM_G1_UNITS];
    logic                    g1_sel;
    logic                    g1_any;

    //////////////////////////////
    // Group 0
    //////////////////////////////
    // No contention so every result is taken at once
    assign alu_wb.ack   = alu_wb.done;
    assign wb_packet[0] = '{valid: alu_wb.done, id: alu_wb.id, data: alu_wb.rd};

    //////////////////////////////
    // Group 1
    //////////////////////////////
    // Flatten the interface array so it can be indexed by sel
    for (genvar u = 0; u < NUM_G1_UNITS; u++) begin : g_g1_flat
        assign g1_done[u]    = g1_wb[u].done;
        assign g1_id[u]      = g1_wb[u].id;
        assign g1_rd[u]      = g1_wb[u].rd;
        assign g1_wb[u].ack  = g1_ack[u];
    end

    priority_encoder u_g1_encoder (
        .vec (g1_done),
        .sel (g1_sel),
        .any (g1_any)
    );

    assign wb_packet[1] = '{valid: g1_any, id: g1_id[g1_sel], data: g1_rd[g1_sel]};

    // Only the chosen unit sees ack, the other keeps holding
    always_comb begin
        g1_ack         = '0;
        g1_ack[g1_sel] = g1_any;
    end

    //////////////////////////////
    // Snoop copy for store forwarding
    //////////////////////////////
    // Group 1 packet delayed by one cycle
    always_ff @(posedge clk) begin
        wb_snoop <= wb_packet[1];
        if (rst) begin
            wb_snoop.valid <= 1'b0;
        end
    end

endmodule

// ==== wb_top.sv ====
// Writeback stage top with ALU, multiplier and divider
// issue_ready has one bit per unit code
// Group 1 index 0 is the multiplier and index 1 the divider
`timescale 1ns/100ps

module wb_top
    import wb_pkg::*;
    import unit_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    // Issue
    input  logic                 issue_valid,
    input  unit_code_t           issue_unit,
    input  op_t                  issue_op,
    input  xlen_t                issue_a,
    input  xlen_t                issue_b,
    input  id_t                  issue_id,
    output logic [NUM_UNITS-1:0] issue_ready,
    // Group 0 result
    output logic                 wb0_valid,
    output id_t                  wb0_id,
    output xlen_t                wb0_data,
    // Group 1 result
    output logic                 wb1_valid,
    output id_t                  wb1_id,
    output xlen_t                wb1_data,
    // Group 1 one cycle late
    output logic                 snoop_valid,
    output id_t                  snoop_id,
    output xlen_t                snoop_data
);

    wb_packet_t wb_packet [NUM_WB_GROUPS];
    wb_packet_t wb_snoop;

    unit_issue_if issue_if [NUM_UNITS] ();
    unit_wb_if    alu_wb_if ();
    unit_wb_if    g1_wb_if [NUM_G1_UNITS] ();

    //////////////////////////////
    // Issue fan-out
    //////////////////////////////
    // Shared payload and valid steered by the unit code
    for (genvar u = 0; u < NUM_UNITS; u++) begin : g_issue
        assign issue_if[u].valid = issue_valid && (issue_unit == unit_code_t'(u));
        assign issue_if[u].op    = issue_op;
        assign issue_if[u].a     = issue_a;
        assign issue_if[u].b     = issue_b;
        assign issue_if[u].id    = issue_id;
        assign issue_ready[u]    = issue_if[u].ready;
    end

    //////////////////////////////
    // Units and writeback
    //////////////////////////////
    alu_unit u_alu (.clk(clk), .rst(rst), .issue(issue_if[UNIT_ALU]), .wb(alu_wb_if));

    // Multiplier takes priority slot 0
    mul_unit u_mul (.clk(clk), .rst(rst), .issue(issue_if[UNIT_MUL]), .wb(g1_wb_if[0]));

    div_unit u_div (.clk(clk), .rst(rst), .issue(issue_if[UNIT_DIV]), .wb(g1_wb_if[1]));

    writeback u_writeback (
        .clk       (clk),
        .rst       (rst),
        .alu_wb    (alu_wb_if),
        .g1_wb     (g1_wb_if),
        .wb_packet (wb_packet),
        .wb_snoop  (wb_snoop)
    );

    assign wb0_valid   = wb_packet[0].valid;
    assign wb0_id      = wb_packet[0].id;
    assign wb0_data    = wb_packet[0].data;
    assign wb1_valid   = wb_packet[1].valid;
    assign wb1_id      = wb_packet[1].id;
    assign wb1_data    = wb_packet[1].data;
    assign snoop_valid = wb_snoop.valid;
    assign snoop_id    = wb_snoop.id;
    assign snoop_data  = wb_snoop.data;

endmodule

// ==== tb_wb_top.sv ====
// Self-checking testbench for the writeback stage
// Expected data and cycle timing come from a reference model of the unit rules
// Random stimulus comes from an LCG with a fixed seed
`timescale 1ns/100ps

module tb_wb_top
    import wb_pkg::*;
    import unit_pkg::*;
();

    // Cycles from acceptance to the transfer edge
    localparam int ALU_LAT    = 1;
    localparam int MUL_LAT    = 3;
    localparam int DIV_LAT    = 33;
    localparam int MAX_WAIT   = 100;
    localparam int DRAIN_WAIT = 200;
    localparam int NUM_IDS    = 1 << ID_W;

    logic                 clk = 1'b0;
    logic                 rst;
    logic                 issue_valid;
    unit_code_t           issue_unit;
    op_t                  issue_op;
    xlen_t                issue_a;
    xlen_t                issue_b;
    id_t                  issue_id;
    logic [NUM_UNITS-1:0] issue_ready;
    logic                 wb0_valid;
    id_t                  wb0_id;
    xlen_t                wb0_data;
    logic                 wb1_valid;
    id_t                  wb1_id;
    xlen_t                wb1_data;
    logic                 snoop_valid;
    id_t                  snoop_id;
    xlen_t                snoop_data;

    // Scoreboard written by the driver on issue and by the monitor on return
    xlen_t       exp_data [NUM_IDS];
    int          accept_cycle [NUM_IDS];
    int          issued [NUM_IDS] = '{default: 0};
    int          returned [NUM_IDS] = '{default: 0};
    id_t         alu_q [$];
    id_t         mul_q [$];
    id_t         div_q [$];
    int          alu_rd = 0;
    int          mul_rd = 0;
    int          div_rd = 0;
    int          cycle = 0;
    int          n_checks = 0;
    int          value_errors = 0;
    int          timeouts = 0;
    logic [31:0] seed = 32'h5e293b5d;
    id_t         next_id = '0;
    // wb1 as seen one cycle back for the snoop check
    logic        prev_valid = 1'b0;
    id_t         prev_id;
    xlen_t       prev_data;

    wb_top u_dut (.*);

    always #50 clk = ~clk;

    always @(posedge clk) cycle <= cycle + 1;

    //////////////////////////////
    // Reference model
    //////////////////////////////
    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic xlen_t ref_result(input unit_code_t unit, input op_t op,
                                         input xlen_t a, input xlen_t b);
        logic [2*XLEN-1:0] prod;
        prod = {{XLEN{1'b0}}, a} * {{XLEN{1'b0}}, b};
        case (unit)
            UNIT_MUL: return (op == MUL_HU) ? prod[2*XLEN-1:XLEN] : prod[XLEN-1:0];
            UNIT_DIV: begin
                // Divide by zero gives all ones and keeps the dividend as remainder
                if (b == '0) return (op == REMU) ? a : '1;
                return (op == REMU) ? a % b : a / b;
            end
            default: begin
                case (op)
                    ALU_ADD: return a + b;
                    ALU_SUB: return a - b;
                    ALU_AND: return a & b;
                    ALU_OR:  return a | b;
                    ALU_XOR: return a ^ b;
                    ALU_SLL: return a << b[$clog2(XLEN)-1:0];
                    ALU_SRL: return a >> b[$clog2(XLEN)-1:0];
                    default: begin
                        // Signs differ so the negative operand is the smaller one
                        if (a[XLEN-1] != b[XLEN-1]) return {{(XLEN-1){1'b0}}, a[XLEN-1]};
                        return {{(XLEN-1){1'b0}}, a < b};
                    end
                endcase
            end
        endcase
    endfunction

    function automatic logic is_pending(input id_t id);
        return issued[id] != returned[id];
    endfunction

    //////////////////////////////
    // Compare tasks
    //////////////////////////////
    task automatic check_flag(input string name, input logic got, input logic exp);
        n_checks++;
        if (got !== exp) begin
            $display("FAIL t=%0t %s got %b expected %b", $time, name, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_id(input string name, input id_t got, input id_t exp);
        n_checks++;
        if (got !== exp) begin
            $display("FAIL t=%0t %s got %0d expected %0d", $time, name, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_data(input string name, input xlen_t got, input xlen_t exp);
        n_checks++;
        if (got !== exp) begin
            $display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
            value_errors++;
        end
    endtask

    //////////////////////////////
    // Driver
    //////////////////////////////
    // First free id at or after next_id with idle cycles while none is free
    task automatic alloc_id(output id_t id);
        int   waited;
        logic found;
        waited = 0;
        found  = 1'b0;
        while (!found) begin
            for (int i = 0; i < NUM_IDS; i++) begin
                if (!found && !is_pending(id_t'(next_id + i))) begin
                    id    = id_t'(next_id + i);
                    found = 1'b1;
                end
            end
            if (!found && waited >= MAX_WAIT) begin
                $display("No instruction id came free within %0d cycles", MAX_WAIT);
                timeouts++;
                id    = next_id;
                found = 1'b1;
            end else if (!found) begin
                issue_valid = 1'b0;
                @(posedge clk);
                #1;
                waited++;
            end
        end
        next_id = id + 1'b1;
    endtask

    // Entered 1 ns after a rising edge and returns 1 ns after the accepting edge
    task automatic send(input unit_code_t unit, input op_t op, input xlen_t a, input xlen_t b);
        id_t id;
        int  waited;
        alloc_id(id);
        issue_valid = 1'b1;
        issue_unit  = unit;
        issue_op    = op;
        issue_a     = a;
        issue_b     = b;
        issue_id    = id;
        waited      = 0;
        @(negedge clk);
        while (!issue_ready[unit] && waited < MAX_WAIT) begin
            @(negedge clk);
            waited++;
        end
        if (!issue_ready[unit]) begin
            $display("Issue of id %0d to unit %s was never accepted", id, unit.name());
            timeouts++;
        end else begin
            // Accepted on the coming edge
            exp_data[id]     = ref_result(unit, op, a, b);
            accept_cycle[id] = cycle + 1;
            issued[id]++;
            case (unit)
                UNIT_ALU: alu_q.push_back(id);
                UNIT_MUL: mul_q.push_back(id);
                default:  div_q.push_back(id);
            endcase
        end
        @(posedge clk);
        #1;
    endtask

    task automatic idle(input int n);
        issue_valid = 1'b0;
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    //////////////////////////////
    // Monitor
    //////////////////////////////
    // Cycle-exact model with ALU and multiplier in order and the multiplier ahead of the divider
    always @(negedge clk) begin : monitor
        logic alu_due;
        logic mul_due;
        logic div_busy;
        logic div_due;
        id_t  exp_id;
        alu_due  = alu_rd < alu_q.size() && accept_cycle[alu_q[alu_rd]] + ALU_LAT - 1 <= cycle;
        mul_due  = mul_rd < mul_q.size() && accept_cycle[mul_q[mul_rd]] + MUL_LAT - 1 <= cycle;
        div_busy = div_rd < div_q.size() && accept_cycle[div_q[div_rd]] <= cycle;
        div_due  = div_busy && accept_cycle[div_q[div_rd]] + DIV_LAT - 1 <= cycle;
        if (!rst) begin
            check_flag("issue_ready[0]", issue_ready[0], 1'b1);
            check_flag("issue_ready[1]", issue_ready[1], 1'b1);
            // Divider stays busy until its result is taken
            check_flag("issue_ready[2]", issue_ready[2], !div_busy);
            check_flag("wb0_valid", wb0_valid, alu_due);
            if (alu_due && wb0_valid) begin
                check_id("wb0_id", wb0_id, alu_q[alu_rd]);
                check_data("wb0_data", wb0_data, exp_data[alu_q[alu_rd]]);
            end
            if (alu_due) begin
                returned[alu_q[alu_rd]]++;
                alu_rd++;
            end
            check_flag("wb1_valid", wb1_valid, mul_due || div_due);
            if (mul_due || div_due) begin
                exp_id = mul_due ? mul_q[mul_rd] : div_q[div_rd];
                if (wb1_valid) begin
                    check_id("wb1_id", wb1_id, exp_id);
                    check_data("wb1_data", wb1_data, exp_data[exp_id]);
                end
                returned[exp_id]++;
                if (mul_due) mul_rd++;
                else div_rd++;
            end
            check_flag("snoop_valid", snoop_valid, prev_valid);
            if (prev_valid) begin
                check_id("snoop_id", snoop_id, prev_id);
                check_data("snoop_data", snoop_data, prev_data);
            end
        end
        prev_valid = wb1_valid;
        prev_id    = wb1_id;
        prev_data  = wb1_data;
    end

    //////////////////////////////
    // Stimulus
    //////////////////////////////
    initial begin : stimulus
        int    waited;
        logic  busy;
        xlen_t r;
        xlen_t a;
        xlen_t b;
        rst         = 1'b1;
        issue_valid = 1'b0;
        issue_unit  = UNIT_ALU;
        issue_op    = '0;
        issue_a     = '0;
        issue_b     = '0;
        issue_id    = '0;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        // Idle cycles right after reset
        idle(3);
        // Back-to-back ALU ops
        for (int n = 0; n < 24; n++) begin
            r = lcg_next();
            a = lcg_next();
            b = lcg_next();
            send(UNIT_ALU, r[2:0], a, b);
        end
        // Back-to-back multiplies
        for (int n = 0; n < 16; n++) begin
            r = lcg_next();
            a = lcg_next();
            b = lcg_next();
            send(UNIT_MUL, r[0] ? MUL_HU : MUL_LO, a, b);
        end
        idle(4);
        // Divider corners
        send(UNIT_DIV, DIVU, 32'd100, 32'd7);
        send(UNIT_DIV, REMU, 32'd100, 32'd7);
        send(UNIT_DIV, DIVU, 32'h8765_4321, 32'd0);
        send(UNIT_DIV, REMU, 32'h8765_4321, 32'd0);
        send(UNIT_DIV, DIVU, 32'd5, 32'd9);
        send(UNIT_DIV, REMU, 32'hffff_ffff, 32'd1);
        // One divide under a long multiplier stream
        a = lcg_next();
        b = lcg_next() >> 20;
        send(UNIT_DIV, DIVU, a, b);
        for (int n = 0; n < 40; n++) begin
            r = lcg_next();
            a = lcg_next();
            b = lcg_next();
            send(UNIT_MUL, r[0] ? MUL_HU : MUL_LO, a, b);
        end
        // Random mix of all units
        for (int n = 0; n < 60; n++) begin
            r = lcg_next();
            a = lcg_next();
            b = (r[7:4] == 4'd0) ? '0 : lcg_next() >> r[12:8];
            case (r % 3)
                0:       send(UNIT_ALU, r[2:0], a, b);
                1:       send(UNIT_MUL, r[0] ? MUL_HU : MUL_LO, a, b);
                default: send(UNIT_DIV, r[0] ? REMU : DIVU, a, b);
            endcase
        end
        issue_valid = 1'b0;
        // Drain everything in flight
        waited = 0;
        busy   = 1'b1;
        while (busy && waited < DRAIN_WAIT) begin
            busy = 1'b0;
            for (int i = 0; i < NUM_IDS; i++) begin
                if (is_pending(id_t'(i))) busy = 1'b1;
            end
            if (busy) begin
                @(posedge clk);
                #1;
                waited++;
            end
        end
        for (int i = 0; i < NUM_IDS; i++) begin
            if (is_pending(id_t'(i))) begin
                $display("Id %0d never returned within %0d cycles", i, DRAIN_WAIT);
                timeouts++;
            end
        end
        idle(2);
        $display("Checks: %0d, value errors: %0d, timeouts: %0d",
                 n_checks, value_errors, timeouts);
        if (value_errors == 0 && timeouts == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// ==== wb_top.f ====
wb_pkg.sv
unit_pkg.sv
unit_wb_if.sv
unit_issue_if.sv
priority_encoder.sv
alu_unit.sv
mul_unit.sv
div_unit.sv
writeback.sv
wb_top.sv
tb_wb_top.sv

// ==== Makefile ====
# Verilator build and run of the writeback stage testbench
# Any variable can be overridden on the command line, e.g. make run OBJ_DIR=build

VERILATOR ?= verilator
TOP       ?= tb_wb_top
FILELIST  ?= wb_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= TESTBENCH PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Status comes from the search, so a missing pass line fails the target
run: compile
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
